// File: hw/valid_pkg.sv
// ==============================
// sizes for the checkpointed valid store
// ==============================

package valid_pkg;

  localparam int N_PREGS = 64;  // physical registers tracked per checkpoint
  localparam int N_CHKPT = 4;   // rename checkpoints, one valid bit each
  localparam int N_WR    = 2;   // write ports, one bank each
  localparam int N_RD    = 3;   // read ports, every bank serves all of them

  localparam int PREG_W = $clog2(N_PREGS);
  localparam int CHK_W  = $clog2(N_CHKPT);
  localparam int LOC_W  = CHK_W + PREG_W;            // checkpoint index on top of register number
  localparam int N_LOC  = N_CHKPT * N_PREGS;         // one bit per location
  localparam int WP_W   = (N_WR > 1) ? $clog2(N_WR) : 1;

  // ==============================
  // index types
  // ==============================
  typedef logic [PREG_W-1:0] pregno_t;
  typedef logic [CHK_W-1:0]  chkpt_ndx_t;
  typedef logic [LOC_W-1:0]  loc_t;
  typedef logic [WP_W-1:0]   wport_t;    // which bank holds the live copy

  // a write request as it arrives from rename or writeback
  // the new valid value is called wbit since bit is a keyword
  typedef struct packed {
    logic       en;     // request is taken at this edge
    chkpt_ndx_t chk;
    pregno_t    preg;
    logic       wbit;   // new valid value
  } wr_req_t;

  // a read request names one bit, there is no enable
  typedef struct packed {
    chkpt_ndx_t chk;
    pregno_t    preg;
  } rd_req_t;

  // location address of a bit, checkpoint in the upper bits
  function automatic loc_t loc_of(chkpt_ndx_t chk, pregno_t preg);
    return {chk, preg};
  endfunction

endpackage

// File: hw/valid_lvt.sv
`timescale 1ns/1ps

// live value table
// remembers for every location which write port wrote it last, so the
// read side can pick the bank that holds the current bit
module valid_lvt (
  input  logic                                         clka,
  input  logic                                         rst,
  input  logic              [valid_pkg::N_WR-1:0]      we,
  input  valid_pkg::loc_t   [valid_pkg::N_WR-1:0]      wa,
  input  valid_pkg::loc_t   [valid_pkg::N_RD-1:0]      ra,
  output valid_pkg::wport_t [valid_pkg::N_RD-1:0]      sel
);

  valid_pkg::wport_t lvt_q [valid_pkg::N_LOC];  // one port index per location, no reset

  // ==============================
  // write side
  // ==============================
  // ports are walked in ascending order so on a same-address collision the
  // last nonblocking assignment, the highest port, is the one that sticks
  always_ff @(posedge clka) begin
    for (int n = 0; n < valid_pkg::N_WR; n++) begin
      if (we[n]) begin
        lvt_q[wa[n]] <= valid_pkg::wport_t'(n);
      end
    end
  end

  // ==============================
  // read side
  // ==============================
  // lookup is registered to line up with the registered bank outputs
  always_ff @(posedge clka) begin
    if (rst) begin
      sel <= '0;  // bank 0 after reset, the sweep writes port 0 everywhere anyway
    end else begin
      for (int r = 0; r < valid_pkg::N_RD; r++) begin
        sel[r] <= lvt_q[ra[r]];  // old entry when the same edge writes it
      end
    end
  end

  // a write with an unknown address would poison the table entry and
  // silently steer later reads to the wrong bank
  for (genvar n = 0; n < valid_pkg::N_WR; n++) begin : g_chk
    a_wa_known : assert property (@(posedge clka) disable iff (rst)
      we[n] |-> !$isunknown(wa[n]))
      else $error("lvt write port %0d has an unknown address", n);
  end

endmodule

// File: hw/valid_bank.sv
`timescale 1ns/1ps

// one write bank of the valid store
// a single write port and one read port for each read port of the store,
// so every read can look into every bank at the same time
module valid_bank (
  input  logic                                    clka,
  input  logic                                    we,    // write enable for this bank's port
  input  valid_pkg::loc_t                         wa,    // location to write
  input  logic                                    din,   // valid bit to store
  input  valid_pkg::loc_t [valid_pkg::N_RD-1:0]   ra,    // one read address per read port
  output logic            [valid_pkg::N_RD-1:0]   dout   // registered read data
);

  // ==============================
  // storage
  // ==============================
  // one bit per location, the bank only holds what its own port wrote
  // and the table decides if that copy is the live one
  logic [valid_pkg::N_LOC-1:0] mem_q;

  // each bit is addressed directly, so there is no word to merge into
  always_ff @(posedge clka) begin
    if (we) begin
      mem_q[wa] <= din;
    end
  end

  // ==============================
  // read ports
  // ==============================
  // the array is sampled before the write above lands, so a read of the
  // location being written returns the old bit
  always_ff @(posedge clka) begin
    for (int r = 0; r < valid_pkg::N_RD; r++) begin
      dout[r] <= mem_q[ra[r]];
    end
  end

endmodule

// File: hw/chkpt_valid_ram.sv
`timescale 1ns/1ps

// multiport checkpoint valid store
// N_WR banks each take one write port, the live value table tracks which
// bank is current for a location, and each read picks its bit through it
module chkpt_valid_ram (
  input  logic                                       clka,
  input  logic                                       rst,
  input  valid_pkg::wr_req_t [valid_pkg::N_WR-1:0]   wr,
  input  valid_pkg::rd_req_t [valid_pkg::N_RD-1:0]   rd,
  output logic               [valid_pkg::N_RD-1:0]   o,
  output logic                                       ready
);

  valid_pkg::loc_t                       sweep_adr_q;  // next location the clearing sweep writes
  logic                                  ready_q;      // sweep has covered every location
  logic                                  rst_q;        // reset seen at the last edge
  logic                                  sweeping;

  logic            [valid_pkg::N_WR-1:0] req_en;       // raw enables from the ports
  logic            [valid_pkg::N_WR-1:0] bank_we;
  valid_pkg::loc_t [valid_pkg::N_WR-1:0] bank_wa;
  logic            [valid_pkg::N_WR-1:0] bank_din;
  logic            [valid_pkg::N_WR-1:0] lvt_we;

  valid_pkg::loc_t   [valid_pkg::N_RD-1:0]                       rd_loc;
  logic              [valid_pkg::N_WR-1:0][valid_pkg::N_RD-1:0]  bank_dout;
  valid_pkg::wport_t [valid_pkg::N_RD-1:0]                       sel;

  // ==============================
  // clearing sweep
  // ==============================
  // after reset every location is written valid, one per cycle, starting on
  // the first edge with rst low; ready goes high with the last one
  always_ff @(posedge clka) begin
    if (rst) begin
      sweep_adr_q <= '0;
      ready_q     <= 1'b0;
    end else if (!ready_q) begin
      sweep_adr_q <= sweep_adr_q + 1'b1;  // wraps back to 0 once the sweep is done
      if (sweep_adr_q == valid_pkg::loc_t'(valid_pkg::N_LOC - 1)) begin
        ready_q <= 1'b1;
      end
    end
  end

  // o reads all ones for the cycle after each edge that saw rst
  always_ff @(posedge clka) begin
    rst_q <= rst;
  end

  assign sweeping = !ready_q;
  assign ready    = ready_q;

  // ==============================
  // write routing
  // ==============================
  // while sweeping every bank writes a 1 at the sweep address and the table
  // points at bank 0 there; afterwards bank n follows port n
  always_comb begin
    for (int n = 0; n < valid_pkg::N_WR; n++) begin
      req_en[n] = wr[n].en;
      if (sweeping) begin
        bank_we[n]  = 1'b1;
        bank_wa[n]  = sweep_adr_q;
        bank_din[n] = 1'b1;
        lvt_we[n]   = (n == 0);  // only port 0 claims the location
      end else begin
        bank_we[n]  = wr[n].en;
        bank_wa[n]  = valid_pkg::loc_of(wr[n].chk, wr[n].preg);
        bank_din[n] = wr[n].wbit;
        lvt_we[n]   = wr[n].en;
      end
    end
  end

  for (genvar n = 0; n < valid_pkg::N_WR; n++) begin : g_bank
    valid_bank u_bank (
      .clka (clka),
      .we   (bank_we[n]),
      .wa   (bank_wa[n]),
      .din  (bank_din[n]),
      .ra   (rd_loc),
      .dout (bank_dout[n])
    );
  end

  // ==============================
  // read path
  // ==============================
  always_comb begin
    for (int r = 0; r < valid_pkg::N_RD; r++) begin
      rd_loc[r] = valid_pkg::loc_of(rd[r].chk, rd[r].preg);  // same address to all banks
    end
  end

  // the table sees the same writes as the banks, so its registered entry
  // always names the bank whose registered output is current
  valid_lvt u_lvt (
    .clka (clka),
    .rst  (rst),
    .we   (lvt_we),
    .wa   (bank_wa),
    .ra   (rd_loc),
    .sel  (sel)
  );

  always_comb begin
    for (int r = 0; r < valid_pkg::N_RD; r++) begin
      o[r] = rst_q | bank_dout[sel[r]][r];
    end
  end

  // a port write during the sweep would be overwritten by the sweep and lost
  a_no_wr_busy : assert property (@(posedge clka) disable iff (rst)
    !ready_q |-> (req_en == '0))
    else $error("write request while the valid store is not ready");

endmodule

// File: hw/valid_store_top.sv
`timescale 1ns/1ps

// top level of the checkpointed register valid store
// write and read requests come in as packed struct arrays, one entry per
// port, and each read port gets its valid bit back one cycle later
module valid_store_top (
  input  logic                                       clka,
  input  logic                                       rst,   // synchronous, starts the clearing sweep
  input  valid_pkg::wr_req_t [valid_pkg::N_WR-1:0]   wr,    // must stay idle while ready is low
  input  valid_pkg::rd_req_t [valid_pkg::N_RD-1:0]   rd,
  output logic               [valid_pkg::N_RD-1:0]   o,     // one valid bit per read port
  output logic                                       ready  // sweep finished, store usable
);

  // ==============================
  // store
  // ==============================
  // everything runs on clka, there is no bus wrapper around the ports
  chkpt_valid_ram u_ram (
    .clka  (clka),
    .rst   (rst),
    .wr    (wr),
    .rd    (rd),
    .o     (o),
    .ready (ready)
  );

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/1ps

// clock and reset for the valid store testbench
// reset is held for the first 3 rising edges, and rst_extra lets the
// testbench pulse it again later in the run
module tb_clock (
  input  logic rst_extra,  // extra reset request from the testbench
  output logic clka,
  output logic rst
);

  logic rst_por;  // power-on part of the reset

  initial begin
    clka = 1'b0;
    forever #5 clka = ~clka;  // 10 ns period
  end

  initial begin
    rst_por <= 1'b1;
    repeat (3) @(posedge clka);
    rst_por <= 1'b0;  // released right after the third edge
  end

  assign rst = rst_por | rst_extra;

endmodule

// File: bench/tb_valid_store.sv
`timescale 1ns/1ps

module tb_valid_store;

  logic clka;
  logic rst;
  logic rst_req;
  valid_pkg::wr_req_t [valid_pkg::N_WR-1:0] wr;
  valid_pkg::rd_req_t [valid_pkg::N_RD-1:0] rd;
  logic [valid_pkg::N_RD-1:0] o;
  logic ready;

  // requests for the next edge, set by the tests and driven by step
  valid_pkg::wr_req_t [valid_pkg::N_WR-1:0] nxt_wr;
  valid_pkg::rd_req_t [valid_pkg::N_RD-1:0] nxt_rd;
  logic nxt_chk;  // compare the reads of this cycle one cycle later
  logic nxt_rst;

  logic model_q [valid_pkg::N_LOC];    // reference copy of every valid bit
  logic [valid_pkg::N_RD-1:0] pend_exp;  // expected o for the reads in flight
  logic pend_chk;

  int seed;
  string cur_name;
  int test_checks;
  int test_errs;
  int tests_run;
  int chk_cnt;
  int err_cnt;

  tb_clock u_clock (
    .rst_extra (rst_req),
    .clka      (clka),
    .rst       (rst)
  );

  valid_store_top i_dut (
    .clka  (clka),
    .rst   (rst),
    .wr    (wr),
    .rd    (rd),
    .o     (o),
    .ready (ready)
  );

  // ==============================
  // helpers
  // ==============================
  function automatic int rand_below(input int n);
    int v;
    v = $random(seed) & 32'h7fff_ffff;  // keep it positive before the modulo
    return v % n;
  endfunction

  // location number with the checkpoint above the register number
  function automatic int loc_num(input int chk, input int preg);
    return chk * valid_pkg::N_PREGS + preg;
  endfunction

  function automatic valid_pkg::wr_req_t make_wr(input int l, input logic b);
    valid_pkg::wr_req_t w;
    w.en   = 1'b1;
    w.chk  = valid_pkg::chkpt_ndx_t'(l / valid_pkg::N_PREGS);
    w.preg = valid_pkg::pregno_t'(l % valid_pkg::N_PREGS);
    w.wbit = b;
    return w;
  endfunction

  function automatic valid_pkg::rd_req_t make_rd(input int l);
    valid_pkg::rd_req_t r;
    r.chk  = valid_pkg::chkpt_ndx_t'(l / valid_pkg::N_PREGS);
    r.preg = valid_pkg::pregno_t'(l % valid_pkg::N_PREGS);
    return r;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    test_checks++;
    chk_cnt++;
    if (exp !== act) begin
      $display("ERR %s expected %0h actual %0h", name, exp, act);
      test_errs++;
      err_cnt++;
    end
  endtask

  // no writes, random reads on every port
  task automatic set_idle(input logic chk_on);
    for (int n = 0; n < valid_pkg::N_WR; n++) begin
      nxt_wr[n] = '0;
    end
    for (int r = 0; r < valid_pkg::N_RD; r++) begin
      nxt_rd[r] = make_rd(rand_below(valid_pkg::N_LOC));
    end
    nxt_chk = chk_on;
  endtask

  // one clock cycle in which the model takes the reads before the writes
  // the requests go out on the rising edge and o is sampled at the falling one
  task automatic step();
    logic [valid_pkg::N_RD-1:0] exp_now;
    int l;
    for (int r = 0; r < valid_pkg::N_RD; r++) begin
      l = loc_num(int'(nxt_rd[r].chk), int'(nxt_rd[r].preg));
      exp_now[r] = model_q[l];  // old value even if written this edge
    end
    // higher port last
    for (int n = 0; n < valid_pkg::N_WR; n++) begin
      if (nxt_wr[n].en) begin
        model_q[loc_num(int'(nxt_wr[n].chk), int'(nxt_wr[n].preg))] = nxt_wr[n].wbit;
      end
    end
    if (nxt_rst) begin
      for (int i = 0; i < valid_pkg::N_LOC; i++) begin
        model_q[i] = 1'b1;  // the sweep sets everything valid again
      end
    end
    @(posedge clka);
    wr      <= nxt_wr;
    rd      <= nxt_rd;
    rst_req <= nxt_rst;
    @(negedge clka);
    if (pend_chk) begin
      check_val(cur_name, 32'(pend_exp), 32'(o));
    end
    pend_exp = exp_now;
    pend_chk = nxt_chk;
  endtask

  task automatic begin_test(input string name);
    cur_name    = name;
    test_checks = 0;
    test_errs   = 0;
  endtask

  // one idle cycle lets the last reads come back before the line is printed
  task automatic end_test();
    set_idle(1'b0);
    step();
    tests_run++;
    $display("test %s: %0d checks, %0d errors", cur_name, test_checks, test_errs);
  endtask

  task automatic finish_run();
    $display("summary: %0d tests, %0d checks, %0d errors", tests_run, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  endtask

  task automatic wait_ready(input int limit);
    int cnt;
    cnt = 0;
    set_idle(1'b0);
    step();
    while (ready !== 1'b1 && cnt < limit) begin
      set_idle(1'b0);  // no writes while the sweep runs
      step();
      cnt++;
    end
    if (ready !== 1'b1) begin
      $display("test %s: ready never rose within %0d cycles after reset", cur_name, limit);
      err_cnt++;
      finish_run();
    end
  endtask

  // random writes on each port, random reads on all ports
  task automatic random_cycle();
    for (int n = 0; n < valid_pkg::N_WR; n++) begin
      nxt_wr[n] = make_wr(rand_below(valid_pkg::N_LOC), 1'(rand_below(2)));
      nxt_wr[n].en = 1'(rand_below(2));
    end
    for (int r = 0; r < valid_pkg::N_RD; r++) begin
      nxt_rd[r] = make_rd(rand_below(valid_pkg::N_LOC));
    end
    nxt_chk = 1'b1;
    step();
  endtask

  // all read ports on one location
  task automatic read_loc(input int l);
    set_idle(1'b1);
    for (int r = 0; r < valid_pkg::N_RD; r++) begin
      nxt_rd[r] = make_rd(l);
    end
    step();
  endtask

  // ==============================
  // test sequence
  // ==============================
  initial begin
    int l;
    logic b;
    seed = 21811;
    tests_run = 0;
    chk_cnt = 0;
    err_cnt = 0;
    pend_chk = 1'b0;
    pend_exp = '0;
    nxt_rst = 1'b0;
    wr <= '0;
    rd <= '0;
    rst_req <= 1'b0;
    for (int i = 0; i < valid_pkg::N_LOC; i++) begin
      model_q[i] = 1'b1;
    end

    begin_test("reset_ready");
    set_idle(1'b0);
    step();
    check_val(cur_name, 32'd0, 32'(ready));  // held low through reset
    wait_ready(400);
    for (int i = 0; i < 32; i++) begin
      set_idle(1'b1);
      for (int r = 0; r < valid_pkg::N_RD; r++) begin
        nxt_rd[r].chk = valid_pkg::chkpt_ndx_t'((i + r) % valid_pkg::N_CHKPT);  // every checkpoint
      end
      step();
    end
    end_test();

    begin_test("single_port");
    for (int i = 0; i < 40; i++) begin
      l = rand_below(valid_pkg::N_LOC);
      set_idle(1'b1);
      nxt_wr[rand_below(valid_pkg::N_WR)] = make_wr(l, 1'(i % 2));  // zeros and ones in turn
      step();
      read_loc(l);
    end
    end_test();

    begin_test("collision");
    for (int i = 0; i < 20; i++) begin
      l = rand_below(valid_pkg::N_LOC);
      b = 1'(rand_below(2));
      set_idle(1'b1);
      nxt_wr[0] = make_wr(l, b);
      nxt_wr[1] = make_wr(l, ~b);  // port 1 must win
      step();
      read_loc(l);
    end
    end_test();

    begin_test("read_during_write");
    for (int i = 0; i < 20; i++) begin
      l = rand_below(valid_pkg::N_LOC);
      set_idle(1'b1);
      for (int r = 0; r < valid_pkg::N_RD; r++) begin
        nxt_rd[r] = make_rd(l);
      end
      nxt_wr[rand_below(valid_pkg::N_WR)] = make_wr(l, ~model_q[l]);  // flips the bit
      step();
      read_loc(l);
    end
    end_test();

    begin_test("random_mix");
    for (int i = 0; i < 2000; i++) begin
      random_cycle();
    end
    end_test();

    begin_test("second_reset");
    for (int i = 0; i < 50; i++) begin
      random_cycle();
    end
    nxt_rst = 1'b1;
    for (int i = 0; i < 3; i++) begin
      set_idle(1'b0);
      step();
    end
    check_val(cur_name, 32'd0, 32'(ready));  // reset took ready away
    nxt_rst = 1'b0;
    wait_ready(400);
    for (int i = 0; i < valid_pkg::N_LOC; i += valid_pkg::N_RD) begin
      set_idle(1'b1);
      for (int r = 0; r < valid_pkg::N_RD; r++) begin
        nxt_rd[r] = make_rd((i + r) % valid_pkg::N_LOC);  // walk every location
      end
      step();
    end
    end_test();

    finish_run();
  end

endmodule

// File: src.f
hw/valid_pkg.sv
hw/valid_lvt.sv
hw/valid_bank.sv
hw/chkpt_valid_ram.sv
hw/valid_store_top.sv
bench/tb_clock.sv
bench/tb_valid_store.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile the valid store testbench with Verilator and run it
# the result is taken from the pass message in the simulation output

set -u

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator was not found in PATH"
  exit 1
fi

verilator --binary --timing --assert \
  -f src.f \
  --top-module tb_valid_store \
  -Mdir obj_dir \
  -o sim_valid_store
status=$?
if [ "$status" -ne 0 ]; then
  echo "compile failed with status $status"
  exit 1
fi

out=$(./obj_dir/sim_valid_store 2>&1)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "All checks passed" <<< "$out"; then
  echo "run_sim: simulation passed"
  exit 0
else
  echo "run_sim: simulation did not pass"
  exit 1
fi
